// File: rtl/gomoku_pkg.sv
package gomoku_pkg;

	localparam int BOARD_N = 5;
	localparam int CELLS   = BOARD_N * BOARD_N;

	// 2 bits per cell, index = row * BOARD_N + col
	typedef logic [2*CELLS-1:0] board_t;

	localparam logic [1:0] CELL_EMPTY = 2'd0;
	localparam logic [1:0] CELL_P0    = 2'd1;
	localparam logic [1:0] CELL_P1    = 2'd2;

	localparam int SCORE_W      = 16;
	localparam int SEARCH_DEPTH = 2;

	// symmetric sentinels, min is most negative plus one
	localparam logic signed [SCORE_W-1:0] SCORE_MAX = {1'b0, {(SCORE_W-1){1'b1}}};
	localparam logic signed [SCORE_W-1:0] SCORE_MIN = -SCORE_MAX;

	typedef logic [2:0] coord_t;	// row or column

	function automatic logic [1:0] cell_at(board_t b, int idx);
		return b[2*idx +: 2];
	endfunction

endpackage

// File: rtl/search_launch.sv
`timescale 1ns/1ps

module search_launch (
	input  logic                                 i_clk,
	input  logic                                 i_rst_n,
	input  logic                                 i_start,
	input  gomoku_pkg::board_t                   i_board,
	input  logic                                 i_side,
	input  logic                                 i_root_finish,
	input  logic signed [gomoku_pkg::SCORE_W-1:0] i_root_point,
	input  gomoku_pkg::coord_t                   i_root_x,
	input  gomoku_pkg::coord_t                   i_root_y,
	output logic                                 o_busy,
	output logic                                 o_done,
	output logic                                 o_root_start,
	output gomoku_pkg::board_t                   o_root_board,
	output logic signed [gomoku_pkg::SCORE_W-1:0] o_root_bound,
	output logic                                 o_side,
	output gomoku_pkg::coord_t                   o_x,
	output gomoku_pkg::coord_t                   o_y,
	output logic signed [gomoku_pkg::SCORE_W-1:0] o_score
);
	import gomoku_pkg::*;

	board_t                     board_r;
	logic                       side_r;
	logic                       busy_r;
	logic                       start_r;
	logic                       done_r;
	logic [4:0]                 empty_cnt;

	assign o_busy       = busy_r;
	assign o_done       = done_r;
	assign o_root_start = start_r;
	assign o_root_board = board_r;
	assign o_side       = side_r;
	// root bound that never prunes
	assign o_root_bound = side_r ? SCORE_MAX : SCORE_MIN;

	always_ff @(posedge i_clk) begin
		if (i_start && !busy_r)
			board_r <= i_board;
	end

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			side_r  <= 1'b0;
			busy_r  <= 1'b0;
			start_r <= 1'b0;
			done_r  <= 1'b0;
			o_x     <= '0;
			o_y     <= '0;
			o_score <= '0;
		end else begin
			start_r <= 1'b0;
			done_r  <= 1'b0;
			if (!busy_r) begin
				if (i_start) begin	// ignored while busy
					side_r  <= i_side;
					busy_r  <= 1'b1;
					start_r <= 1'b1;
				end
			end else if (i_root_finish) begin
				o_x     <= i_root_x;
				o_y     <= i_root_y;
				o_score <= i_root_point;
				done_r  <= 1'b1;
				busy_r  <= 1'b0;
			end
		end
	end

	always_comb begin
		empty_cnt = '0;
		for (int i = 0; i < CELLS; i++)
			if (cell_at(i_board, i) == CELL_EMPTY)
				empty_cnt = empty_cnt + 5'd1;
	end

	// every level needs a free cell to place on
	a_enough_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_start && !busy_r) |-> (empty_cnt >= SEARCH_DEPTH));

	a_finish_when_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_root_finish |-> busy_r);

endmodule

// File: rtl/minmax_node.sv
`timescale 1ns/1ps

module minmax_node #(
	parameter int LEVEL = 0
) (
	input  logic                                 i_clk,
	input  logic                                 i_rst_n,
	input  logic                                 i_side,
	input  logic                                 i_start,
	input  gomoku_pkg::board_t                   i_board,
	input  logic signed [gomoku_pkg::SCORE_W-1:0] i_prev_point,
	input  logic                                 i_next,
	input  logic signed [gomoku_pkg::SCORE_W-1:0] i_point,
	output logic                                 o_start,
	output gomoku_pkg::board_t                   o_board,
	output logic signed [gomoku_pkg::SCORE_W-1:0] o_point,
	output logic                                 o_finish,
	output gomoku_pkg::coord_t                   o_x,
	output gomoku_pkg::coord_t                   o_y
);
	import gomoku_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_SCAN, S_WAIT} state_t;

	state_t                     state_r, state_w;
	logic [4:0]                 ptr_r, ptr_w;
	logic [4:0]                 cand_r, cand_w;
	logic signed [SCORE_W-1:0]  best_r, best_w;
	coord_t                     best_x_r, best_x_w;
	coord_t                     best_y_r, best_y_w;
	board_t                     board_r, board_w;
	logic                       start_r, start_w;
	logic                       finish_r, finish_w;

	logic                       mover;	// 1 means player 1, the maximizer
	logic [1:0]                 stone;
	logic                       scan_end;
	logic [4:0]                 scan_idx;
	logic                       better;
	logic signed [SCORE_W-1:0]  next_best;
	logic                       prune;

	assign mover    = i_side ^ (LEVEL % 2 != 0);
	assign stone    = mover ? CELL_P1 : CELL_P0;
	assign scan_end = (ptr_r == 5'(CELLS));
	assign scan_idx = scan_end ? 5'd0 : ptr_r;

	// strict improvement keeps the earliest cell on ties
	assign better    = mover ? (i_point > best_r) : (i_point < best_r);
	assign next_best = better ? i_point : best_r;
	assign prune     = mover ? (next_best >= i_prev_point) : (next_best <= i_prev_point);

	assign o_start  = start_r;
	assign o_board  = board_r;
	assign o_point  = best_r;
	assign o_finish = finish_r;
	assign o_x      = best_x_r;
	assign o_y      = best_y_r;

	always_comb begin
		state_w  = state_r;
		ptr_w    = ptr_r;
		cand_w   = cand_r;
		best_w   = best_r;
		best_x_w = best_x_r;
		best_y_w = best_y_r;
		board_w  = board_r;
		start_w  = 1'b0;
		finish_w = 1'b0;
		case (state_r)
			S_IDLE: begin
				if (i_start) begin
					ptr_w   = '0;
					best_w  = mover ? SCORE_MIN : SCORE_MAX;
					state_w = S_SCAN;
				end
			end
			S_SCAN: begin
				if (scan_end) begin
					finish_w = 1'b1;
					state_w  = S_IDLE;
				end else if (cell_at(i_board, scan_idx) == CELL_EMPTY) begin
					board_w                 = i_board;
					board_w[2*scan_idx +: 2] = stone;	// place candidate
					cand_w                  = scan_idx;
					start_w                 = 1'b1;
					ptr_w                   = ptr_r + 5'd1;
					state_w                 = S_WAIT;
				end else begin
					ptr_w = ptr_r + 5'd1;
				end
			end
			S_WAIT: begin
				if (i_next) begin
					best_w = next_best;
					if (better) begin
						best_x_w = coord_t'(cand_r % BOARD_N);
						best_y_w = coord_t'(cand_r / BOARD_N);
					end
					if (prune) begin	// parent would never take this branch
						finish_w = 1'b1;
						state_w  = S_IDLE;
					end else begin
						state_w = S_SCAN;
					end
				end
			end
			default: state_w = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		board_r <= board_w;
		cand_r  <= cand_w;
	end

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r  <= S_IDLE;
			ptr_r    <= '0;
			best_r   <= '0;
			best_x_r <= '0;
			best_y_r <= '0;
			start_r  <= 1'b0;
			finish_r <= 1'b0;
		end else begin
			state_r  <= state_w;
			ptr_r    <= ptr_w;
			best_r   <= best_w;
			best_x_r <= best_x_w;
			best_y_r <= best_y_w;
			start_r  <= start_w;
			finish_r <= finish_w;
		end
	end

	// child answers only to a start we issued
	a_next_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_next |-> (state_r == S_WAIT));

endmodule

// File: rtl/board_scorer.sv
`timescale 1ns/1ps

module board_scorer (
	input  logic                                 i_clk,
	input  logic                                 i_rst_n,
	input  logic                                 i_start,
	input  gomoku_pkg::board_t                   i_board,
	output logic signed [gomoku_pkg::SCORE_W-1:0] o_point,
	output logic                                 o_finish
);
	import gomoku_pkg::*;

	logic signed [SCORE_W-1:0] score;
	logic [1:0]                here;

	// +1 for a player 1 pair, -1 for a player 0 pair
	function automatic logic signed [SCORE_W-1:0] pair_val(logic [1:0] a, logic [1:0] b);
		if (a == CELL_P1 && b == CELL_P1)
			return 1;
		else if (a == CELL_P0 && b == CELL_P0)
			return -1;
		else
			return 0;
	endfunction

	always_comb begin
		score = '0;
		here  = CELL_EMPTY;
		for (int r = 0; r < BOARD_N; r++) begin
			for (int c = 0; c < BOARD_N; c++) begin
				here = cell_at(i_board, r*BOARD_N + c);
				if (c < BOARD_N - 1)	// right neighbour
					score = score + pair_val(here, cell_at(i_board, r*BOARD_N + c + 1));
				if (r < BOARD_N - 1)	// lower neighbour
					score = score + pair_val(here, cell_at(i_board, (r+1)*BOARD_N + c));
			end
		end
	end

	always_ff @(posedge i_clk, negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_point  <= '0;
			o_finish <= 1'b0;
		end else begin
			o_finish <= i_start;
			if (i_start)
				o_point <= score;
		end
	end

endmodule

// File: rtl/gomoku_search_top.sv
`timescale 1ns/1ps

module gomoku_search_top (
	input  logic                                 i_clk,
	input  logic                                 i_rst_n,
	input  logic                                 i_start,
	input  gomoku_pkg::board_t                   i_board,
	input  logic                                 i_side,
	output logic                                 o_busy,
	output logic                                 o_done,
	output gomoku_pkg::coord_t                   o_x,
	output gomoku_pkg::coord_t                   o_y,
	output logic signed [gomoku_pkg::SCORE_W-1:0] o_score
);
	import gomoku_pkg::*;

	// index k is the input side of level k, SEARCH_DEPTH is the scorer
	logic                      lvl_start  [0:SEARCH_DEPTH];
	board_t                    lvl_board  [0:SEARCH_DEPTH];
	logic signed [SCORE_W-1:0] lvl_point  [0:SEARCH_DEPTH];
	logic                      lvl_finish [0:SEARCH_DEPTH];
	logic signed [SCORE_W-1:0] lvl_bound  [0:SEARCH_DEPTH-1];
	coord_t                    lvl_x      [0:SEARCH_DEPTH-1];
	coord_t                    lvl_y      [0:SEARCH_DEPTH-1];
	logic                      root_side;

	search_launch u_launch (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (i_start),
		.i_board       (i_board),
		.i_side        (i_side),
		.i_root_finish (lvl_finish[0]),
		.i_root_point  (lvl_point[0]),
		.i_root_x      (lvl_x[0]),
		.i_root_y      (lvl_y[0]),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_root_start  (lvl_start[0]),
		.o_root_board  (lvl_board[0]),
		.o_root_bound  (lvl_bound[0]),
		.o_side        (root_side),
		.o_x           (o_x),
		.o_y           (o_y),
		.o_score       (o_score)
	);

	for (genvar k = 0; k < SEARCH_DEPTH; k++) begin : g_level
		if (k > 0) begin : g_bound
			assign lvl_bound[k] = lvl_point[k-1];	// parent's running best
		end

		minmax_node #(.LEVEL(k)) u_node (
			.i_clk        (i_clk),
			.i_rst_n      (i_rst_n),
			.i_side       (root_side),
			.i_start      (lvl_start[k]),
			.i_board      (lvl_board[k]),
			.i_prev_point (lvl_bound[k]),
			.i_next       (lvl_finish[k+1]),
			.i_point      (lvl_point[k+1]),
			.o_start      (lvl_start[k+1]),
			.o_board      (lvl_board[k+1]),
			.o_point      (lvl_point[k]),
			.o_finish     (lvl_finish[k]),
			.o_x          (lvl_x[k]),
			.o_y          (lvl_y[k])
		);
	end

	board_scorer u_scorer (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_start  (lvl_start[SEARCH_DEPTH]),
		.i_board  (lvl_board[SEARCH_DEPTH]),
		.o_point  (lvl_point[SEARCH_DEPTH]),
		.o_finish (lvl_finish[SEARCH_DEPTH])
	);

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic o_clk,
	output logic o_rst_n
);
	localparam int HALF_PERIOD = 50;	// 100 ns clock
	localparam int RESET_CYCLES = 5;

	initial begin
		o_clk   = 1'b0;
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

	always #HALF_PERIOD o_clk = ~o_clk;

endmodule

// File: tb/tb_gomoku_search.sv
`timescale 1ns/1ps

module tb_gomoku_search;
	import gomoku_pkg::*;

	localparam int DONE_TIMEOUT  = 20000;	// cycles per request
	localparam int RESET_TIMEOUT = 20;
	localparam int BUSY_POKE     = 2;	// cycle of the ignored start
	localparam string STIM_FILE  = "tb/gomoku_stimulus.txt";

	logic                      clk;
	logic                      rst_n;
	logic                      start;
	board_t                    board;
	logic                      side;
	logic                      busy;
	logic                      done;
	coord_t                    x;
	coord_t                    y;
	logic signed [SCORE_W-1:0] score;

	clock_gen u_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	gomoku_search_top uut (
		.i_clk   (clk),
		.i_rst_n (rst_n),
		.i_start (start),
		.i_board (board),
		.i_side  (side),
		.o_busy  (busy),
		.o_done  (done),
		.o_x     (x),
		.o_y     (y),
		.o_score (score)
	);

	// inputs change and outputs are sampled 1 ns after the edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_val(input string name, input logic signed [63:0] got,
			input logic signed [63:0] exp_val);
		if (got !== exp_val) begin
			$display("Error: time %0t, %s = %0d, expected %0d", $time, name, got, exp_val);
			$display("Test failed");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1) begin
			tick();
			n++;
			if (n > RESET_TIMEOUT) begin
				$display("Test failed");
				$fatal(1, "reset was never released");
			end
		end
	endtask

	task automatic run_case(input board_t b, input logic s, input coord_t ex,
			input coord_t ey, input logic signed [SCORE_W-1:0] es);
		int n;
		n = 0;
		board = b;
		side  = s;
		start = 1'b1;
		tick();
		start = 1'b0;
		check_val("o_busy", busy, 1);
		while (done !== 1'b1) begin
			if (n == BUSY_POKE) begin	// another request while busy, must be dropped
				board = ~b;
				side  = ~s;
				start = 1'b1;
			end else begin
				start = 1'b0;
			end
			tick();
			n++;
			if (n > DONE_TIMEOUT) begin
				$display("Test failed");
				$fatal(1, "search did not finish within %0d cycles", DONE_TIMEOUT);
			end
			if (done !== 1'b1)
				check_val("o_busy", busy, 1);
		end
		check_val("o_busy", busy, 0);	// falls with done
		check_val("o_x", x, ex);
		check_val("o_y", y, ey);
		check_val("o_score", score, es);
		tick();
		check_val("o_done", done, 0);	// single cycle pulse
	endtask

	initial begin
		string       line;
		int          fd;
		int          cnt;
		int          n_cases;
		logic [63:0] f_board;
		logic [63:0] f_side;
		logic [63:0] f_x;
		logic [63:0] f_y;
		logic [63:0] f_score;

		start   = 1'b0;
		board   = '0;
		side    = 1'b0;
		n_cases = 0;

		wait_reset();
		tick();
		check_val("o_busy", busy, 0);
		check_val("o_done", done, 0);

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Test failed");
			$fatal(1, "cannot open the stimulus file %s", STIM_FILE);
		end

		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;	// comment or blank
			cnt = $sscanf(line, "%h %h %h %h %h", f_board, f_side, f_x, f_y, f_score);
			if (cnt != 5) begin
				$display("Test failed");
				$fatal(1, "stimulus line %0d cannot be parsed", n_cases + 1);
			end
			run_case(board_t'(f_board), f_side[0], coord_t'(f_x), coord_t'(f_y),
				f_score[SCORE_W-1:0]);
			n_cases++;
		end
		$fclose(fd);

		if (n_cases == 0) begin
			$display("Test failed");
			$fatal(1, "the stimulus file holds no cases");
		end else begin
			$display("%0d cases checked", n_cases);
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// File: tb/gomoku_stimulus.txt
# board (hex, cell i in bits 2i+1:2i, 0 empty 1 player0 2 player1), side to move,
# expected x (column), expected y (row), expected score (hex, 16 bit two's complement)
0000000000000 1 0 0 0000
0000000000000 0 0 0 0000
0000002000000 1 2 1 0001
0000002000000 0 0 0 0001
0000002000001 1 2 1 0000
0000002000001 0 1 0 0000
140000000000a 1 2 0 0000
140000000000a 0 3 3 0000
0000000011000 1 2 1 ffff
0000000011000 0 2 1 fffe
0000000022000 1 2 1 0002
0000000022000 0 2 1 0001
0000012a00000 1 0 1 0002
0000012a00000 0 4 1 0002

// File: gomoku_search_top.f
rtl/gomoku_pkg.sv
rtl/search_launch.sv
rtl/minmax_node.sv
rtl/board_scorer.sv
rtl/gomoku_search_top.sv
tb/clock_gen.sv
tb/tb_gomoku_search.sv

// File: Makefile
# Verilator build and run of the gomoku search testbench

VERILATOR ?= verilator
TOP       ?= tb_gomoku_search
FILELIST  ?= gomoku_search_top.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(OBJ_DIR) \
		--top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
